/* verilog/sdram_port_pkg.sv */
package sdram_port_pkg;

  typedef logic [21:0] word_addr_t;  // 4M words
  typedef logic [15:0] data_t;
  typedef logic [19:0] line_tag_t;   // word address without the two low bits
  typedef logic [17:0] page_addr_t;  // word address without the four low bits
  typedef logic [3:0]  beat_idx_t;   // beat within a burst
  typedef logic [4:0]  burst_len_t;  // 1 to 16 beats

  localparam int LINE_WORDS = 4;
  localparam int PAGE_WORDS = 16;

  // lengths sent to the burst controller
  localparam burst_len_t BURST_READ_LINE    = 5'd4;
  localparam burst_len_t BURST_WRITE_SINGLE = 5'd1;
  localparam burst_len_t BURST_WRITE_PAGE   = 5'd16;

  typedef enum logic [1:0] {
    arb_idle,
    arb_read_fill,     // four-beat cache line fill
    arb_write_single,  // one-beat user write
    arb_write_flush    // sixteen-beat page flush
  } arb_state_t;

endpackage

/* verilog/burst_beat_counter.sv */
`timescale 1ns/1ps

module burst_beat_counter (
  input  logic                     clk,
  input  logic                     sys_rst_n,
  input  logic                     beat_clear,
  input  logic                     beat_ack,
  input  sdram_port_pkg::burst_len_t burst_len,
  output sdram_port_pkg::beat_idx_t  beat_idx,
  output logic                     last_beat
);

  import sdram_port_pkg::*;

  beat_idx_t beat_cnt;
  logic      burst_over;  // high between bursts

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      beat_cnt   <= '0;
      burst_over <= 1'b1;
    end else if (beat_clear) begin
      beat_cnt   <= '0;
      burst_over <= 1'b0;
    end else if (beat_ack) begin
      beat_cnt <= beat_cnt + 1'b1;
      if (last_beat) begin
        burst_over <= 1'b1;
      end
    end
  end

  assign beat_idx  = beat_cnt;
  assign last_beat = beat_ack && ((burst_len_t'(beat_cnt) + 5'd1) == burst_len);

  // controller must stop acknowledging once the burst length is reached
  a_no_ack_after_last : assert property (
    @(posedge clk) disable iff (!sys_rst_n) burst_over |-> !beat_ack
  );

endmodule

/* verilog/read_line_cache.sv */
`timescale 1ns/1ps

module read_line_cache (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  sdram_port_pkg::word_addr_t address,
  input  logic                       read_req,
  input  logic                       write_req,
  input  logic                       write_en,
  input  logic                       ctrl_rd_ack,
  input  sdram_port_pkg::data_t      ctrl_dout,
  input  sdram_port_pkg::beat_idx_t  beat_idx,
  input  logic                       fill_done,
  output logic                       fill_req,
  output logic                       read_ack,
  output sdram_port_pkg::data_t      data_out
);

  import sdram_port_pkg::*;

  data_t     line_q [LINE_WORDS];
  line_tag_t line_tag;
  logic      line_valid;
  logic      read_req_d;
  logic      write_req_d;
  logic      rd_rise;
  logic      hit;
  logic [1:0] word_sel;
  data_t     fill_word;  // requested word at the end of a fill

  assign rd_rise  = read_req && !read_req_d;
  assign word_sel = address[1:0];
  assign hit      = line_valid && (line_tag == address[21:2]);

  // last beat may carry the requested word itself
  assign fill_word = (ctrl_rd_ack && (beat_idx[1:0] == word_sel)) ? ctrl_dout
                                                                   : line_q[word_sel];

  always_ff @(posedge clk) begin
    if (fill_req && ctrl_rd_ack) begin
      line_q[beat_idx[1:0]] <= ctrl_dout;
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      read_req_d  <= 1'b0;
      write_req_d <= 1'b0;
      line_tag    <= '0;
      line_valid  <= 1'b0;
      fill_req    <= 1'b0;
      read_ack    <= 1'b0;
      data_out    <= '0;
    end else begin
      read_req_d  <= read_req;
      write_req_d <= write_req;
      if (rd_rise) begin
        if (hit) begin
          read_ack <= 1'b1;
          data_out <= line_q[word_sel];
        end else begin
          line_valid <= 1'b0;  // line is being replaced
          fill_req   <= 1'b1;
        end
      end else if (fill_done) begin
        fill_req   <= 1'b0;
        line_valid <= 1'b1;
        line_tag   <= address[21:2];
        read_ack   <= 1'b1;
        data_out   <= fill_word;
      end
      if (!read_req) begin
        read_ack <= 1'b0;
        data_out <= '0;
      end
      if ((write_req && !write_req_d) || write_en) begin
        line_valid <= 1'b0;  // any write may hit the cached line
      end
    end
  end

endmodule

/* verilog/write_stream_buffer.sv */
`timescale 1ns/1ps

module write_stream_buffer (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  sdram_port_pkg::word_addr_t address,
  input  sdram_port_pkg::data_t      data_in,
  input  logic                       write_latch_address,
  input  logic                       write_en,
  input  sdram_port_pkg::beat_idx_t  beat_idx,
  input  logic                       flush_done,
  output logic                       flush_req,
  output sdram_port_pkg::page_addr_t flush_page,
  output sdram_port_pkg::data_t      flush_word
);

  import sdram_port_pkg::*;

  word_addr_t stream_addr;
  word_addr_t cur_addr;       // latched address wins in the same cycle
  beat_idx_t  cur_offset;
  logic       page_done;

  // word 15 goes straight to the back page
  data_t front_q [PAGE_WORDS-1];
  data_t back_q  [PAGE_WORDS];

  assign cur_addr   = write_latch_address ? address : stream_addr;
  assign cur_offset = cur_addr[3:0];
  assign page_done  = write_en && (cur_offset == beat_idx_t'(PAGE_WORDS - 1));

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      stream_addr <= '0;
    end else if (write_en) begin
      stream_addr <= cur_addr + 1'b1;
    end else begin
      stream_addr <= cur_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (write_en && !page_done) begin
      front_q[cur_offset] <= data_in;
    end
    if (page_done) begin
      for (int i = 0; i < PAGE_WORDS - 1; i++) begin
        back_q[i] <= front_q[i];
      end
      back_q[PAGE_WORDS-1] <= data_in;
      flush_page           <= cur_addr[21:4];
    end
  end

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      flush_req <= 1'b0;
    end else if (page_done) begin
      flush_req <= 1'b1;
    end else if (flush_done) begin
      flush_req <= 1'b0;
    end
  end

  assign flush_word = back_q[beat_idx];  // read by the fsm beat by beat

  // back page is still owned by the pending flush
  a_no_page_while_flushing : assert property (
    @(posedge clk) disable iff (!sys_rst_n) page_done |-> !flush_req
  );

endmodule

/* verilog/sdram_arbiter_fsm.sv */
`timescale 1ns/1ps

module sdram_arbiter_fsm (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  sdram_port_pkg::word_addr_t address,
  input  logic                       write_req,
  input  logic                       fill_req,
  input  logic                       flush_req,
  input  sdram_port_pkg::page_addr_t flush_page,
  input  sdram_port_pkg::beat_idx_t  beat_idx,
  input  logic                       last_beat,
  input  logic                       ctrl_rd_ack,
  input  logic                       ctrl_wr_ack,
  input  logic                       ctrl_init_done,
  output logic                       ctrl_rd_req,
  output logic                       ctrl_wr_req,
  output sdram_port_pkg::word_addr_t ctrl_addr,
  output sdram_port_pkg::burst_len_t ctrl_burst,
  output logic                       din_from_stream,
  output logic                       fill_done,
  output logic                       flush_done,
  output logic                       write_ack,
  output logic                       busy,
  output logic                       beat_clear
);

  import sdram_port_pkg::*;

  arb_state_t state;
  line_tag_t  fill_tag;
  logic       write_req_d;
  logic       wr_pending;  // single write waiting for the controller
  logic       can_start;
  logic       grant_fill;
  logic       grant_single;
  logic       grant_flush;

  assign fill_tag  = address[21:2];
  assign can_start = (state == arb_idle) && ctrl_init_done;

  // fill first, then single write, then page flush
  assign grant_fill   = can_start && fill_req;
  assign grant_single = can_start && !fill_req && wr_pending;
  assign grant_flush  = can_start && !fill_req && !wr_pending && flush_req;
  assign beat_clear   = grant_fill || grant_single || grant_flush;

  always_ff @(posedge clk or negedge sys_rst_n) begin
    if (!sys_rst_n) begin
      state       <= arb_idle;
      ctrl_rd_req <= 1'b0;
      ctrl_wr_req <= 1'b0;
      write_req_d <= 1'b0;
      wr_pending  <= 1'b0;
      write_ack   <= 1'b0;
    end else begin
      write_req_d <= write_req;
      write_ack   <= 1'b0;
      if (write_req && !write_req_d) begin
        wr_pending <= 1'b1;
      end
      case (state)
        arb_idle: begin
          if (grant_fill) begin
            state       <= arb_read_fill;
            ctrl_rd_req <= 1'b1;
          end else if (grant_single) begin
            state       <= arb_write_single;
            ctrl_wr_req <= 1'b1;
          end else if (grant_flush) begin
            state       <= arb_write_flush;
            ctrl_wr_req <= 1'b1;
          end
        end
        arb_read_fill: begin
          if (last_beat) begin
            state       <= arb_idle;
            ctrl_rd_req <= 1'b0;
          end
        end
        arb_write_single: begin
          if (last_beat) begin
            state       <= arb_idle;
            ctrl_wr_req <= 1'b0;
            wr_pending  <= 1'b0;
            write_ack   <= 1'b1;
          end
        end
        arb_write_flush: begin
          if (last_beat) begin
            state       <= arb_idle;
            ctrl_wr_req <= 1'b0;
          end
        end
        default: state <= arb_idle;
      endcase
    end
  end

  // burst address and length, loaded as the burst is granted
  always_ff @(posedge clk) begin
    if (grant_fill) begin
      ctrl_addr  <= {fill_tag, 2'b00};
      ctrl_burst <= BURST_READ_LINE;
    end else if (grant_single) begin
      ctrl_addr  <= address;
      ctrl_burst <= BURST_WRITE_SINGLE;
    end else if (grant_flush) begin
      ctrl_addr  <= {flush_page, 4'b0000};
      ctrl_burst <= BURST_WRITE_PAGE;
    end
  end

  assign fill_done       = (state == arb_read_fill) && last_beat;
  assign flush_done      = (state == arb_write_flush) && last_beat;
  assign din_from_stream = (state == arb_write_flush);
  assign busy            = (state != arb_idle);

  a_one_request : assert property (
    @(posedge clk) disable iff (!sys_rst_n) !(ctrl_rd_req && ctrl_wr_req)
  );

  a_req_after_init : assert property (
    @(posedge clk) disable iff (!sys_rst_n) (ctrl_rd_req || ctrl_wr_req) |-> ctrl_init_done
  );

  // acknowledges must match the direction of the open burst
  a_rd_ack_in_fill : assert property (
    @(posedge clk) disable iff (!sys_rst_n) ctrl_rd_ack |-> (state == arb_read_fill)
  );

  a_wr_ack_in_write : assert property (
    @(posedge clk) disable iff (!sys_rst_n)
      ctrl_wr_ack |-> (state == arb_write_single) || (state == arb_write_flush)
  );

endmodule

/* verilog/sdram_front_end.sv */
`timescale 1ns/1ps

module sdram_front_end (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  sdram_port_pkg::word_addr_t address,
  input  sdram_port_pkg::data_t      data_in,
  input  logic                       read_req,
  input  logic                       write_req,
  input  logic                       write_latch_address,
  input  logic                       write_en,
  output sdram_port_pkg::data_t      data_out,
  output logic                       read_ack,
  output logic                       write_ack,
  output logic                       busy,
  output logic                       ctrl_rd_req,
  output logic                       ctrl_wr_req,
  output sdram_port_pkg::word_addr_t ctrl_addr,
  output sdram_port_pkg::burst_len_t ctrl_burst,
  output sdram_port_pkg::data_t      ctrl_din,
  input  logic                       ctrl_rd_ack,
  input  logic                       ctrl_wr_ack,
  input  logic                       ctrl_init_done,
  input  sdram_port_pkg::data_t      ctrl_dout
);

  import sdram_port_pkg::*;

  logic       fill_req;
  logic       fill_done;
  logic       flush_req;
  logic       flush_done;
  page_addr_t flush_page;
  data_t      flush_word;
  beat_idx_t  beat_idx;
  logic       beat_clear;
  logic       beat_ack;
  logic       last_beat;
  logic       din_from_stream;

  assign beat_ack = ctrl_rd_ack || ctrl_wr_ack;
  assign ctrl_din = din_from_stream ? flush_word : data_in;  // valid in the ack cycle

  read_line_cache i_read_line_cache (
    .clk         (clk),
    .sys_rst_n   (sys_rst_n),
    .address     (address),
    .read_req    (read_req),
    .write_req   (write_req),
    .write_en    (write_en),
    .ctrl_rd_ack (ctrl_rd_ack),
    .ctrl_dout   (ctrl_dout),
    .beat_idx    (beat_idx),
    .fill_done   (fill_done),
    .fill_req    (fill_req),
    .read_ack    (read_ack),
    .data_out    (data_out)
  );

  write_stream_buffer i_write_stream_buffer (
    .clk                 (clk),
    .sys_rst_n           (sys_rst_n),
    .address             (address),
    .data_in             (data_in),
    .write_latch_address (write_latch_address),
    .write_en            (write_en),
    .beat_idx            (beat_idx),
    .flush_done          (flush_done),
    .flush_req           (flush_req),
    .flush_page          (flush_page),
    .flush_word          (flush_word)
  );

  sdram_arbiter_fsm i_sdram_arbiter_fsm (
    .clk             (clk),
    .sys_rst_n       (sys_rst_n),
    .address         (address),
    .write_req       (write_req),
    .fill_req        (fill_req),
    .flush_req       (flush_req),
    .flush_page      (flush_page),
    .beat_idx        (beat_idx),
    .last_beat       (last_beat),
    .ctrl_rd_ack     (ctrl_rd_ack),
    .ctrl_wr_ack     (ctrl_wr_ack),
    .ctrl_init_done  (ctrl_init_done),
    .ctrl_rd_req     (ctrl_rd_req),
    .ctrl_wr_req     (ctrl_wr_req),
    .ctrl_addr       (ctrl_addr),
    .ctrl_burst      (ctrl_burst),
    .din_from_stream (din_from_stream),
    .fill_done       (fill_done),
    .flush_done      (flush_done),
    .write_ack       (write_ack),
    .busy            (busy),
    .beat_clear      (beat_clear)
  );

  burst_beat_counter i_burst_beat_counter (
    .clk        (clk),
    .sys_rst_n  (sys_rst_n),
    .beat_clear (beat_clear),
    .beat_ack   (beat_ack),
    .burst_len  (ctrl_burst),
    .beat_idx   (beat_idx),
    .last_beat  (last_beat)
  );

endmodule

/* verification/sdram_ctrl_model.sv */
`timescale 1ns/1ps

module sdram_ctrl_model (
  input  logic                       clk,
  input  logic                       sys_rst_n,
  input  logic                       ctrl_rd_req,
  input  logic                       ctrl_wr_req,
  input  sdram_port_pkg::word_addr_t ctrl_addr,
  input  sdram_port_pkg::burst_len_t ctrl_burst,
  input  sdram_port_pkg::data_t      ctrl_din,
  output logic                       ctrl_rd_ack,
  output logic                       ctrl_wr_ack,
  output sdram_port_pkg::data_t      ctrl_dout,
  output logic                       ctrl_init_done,
  output int                         rd_burst_count
);

  import sdram_port_pkg::*;

  localparam int MEM_WORDS = 1 << 22;

  data_t      mem [MEM_WORDS];
  word_addr_t base;
  word_addr_t beat_addr;
  int         len;
  int         gap;
  logic       is_read;

  // untouched words, mixes every address bit
  function automatic data_t fill_pattern(input word_addr_t a);
    word_addr_t mix;
    mix = a * 22'h2c9b + (a >> 9) + 22'h3a5c;
    return mix[15:0];
  endfunction

  initial begin
    ctrl_rd_ack    = 1'b0;
    ctrl_wr_ack    = 1'b0;
    ctrl_dout      = '0;
    ctrl_init_done = 1'b0;
    rd_burst_count = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = fill_pattern(i[21:0]);
    end
    while (sys_rst_n !== 1'b1) begin
      @(negedge clk);
    end
    repeat (20) @(negedge clk);  // power-up and mode register sequence
    ctrl_init_done = 1'b1;
    forever begin
      @(negedge clk);
      if (ctrl_rd_req || ctrl_wr_req) begin
        base    = ctrl_addr;
        len     = int'(ctrl_burst);
        is_read = ctrl_rd_req;
        if (is_read) begin
          rd_burst_count++;
        end
        @(negedge clk);  // command accepted before the first beat
        for (int b = 0; b < len; b++) begin
          gap       = $urandom % 4;
          beat_addr = base + b[21:0];
          repeat (gap) @(negedge clk);
          if (is_read) begin
            ctrl_dout   = mem[beat_addr];
            ctrl_rd_ack = 1'b1;
          end else begin
            ctrl_wr_ack = 1'b1;
          end
          @(posedge clk);
          if (!is_read) begin
            mem[beat_addr] = ctrl_din;  // word is valid in the ack cycle
          end
          @(negedge clk);
          ctrl_rd_ack = 1'b0;
          ctrl_wr_ack = 1'b0;
        end
      end
    end
  end

endmodule

/* verification/tb_sdram_front_end.sv */
`timescale 1ns/1ps

module tb_sdram_front_end;

  import sdram_port_pkg::*;

  localparam int WAIT_LIMIT = 200;  // cycles allowed per wait loop

  logic       clk;
  logic       sys_rst_n;
  word_addr_t address;
  data_t      data_in;
  logic       read_req;
  logic       write_req;
  logic       write_latch_address;
  logic       write_en;
  data_t      data_out;
  logic       read_ack;
  logic       write_ack;
  logic       busy;
  logic       ctrl_rd_req;
  logic       ctrl_wr_req;
  word_addr_t ctrl_addr;
  burst_len_t ctrl_burst;
  data_t      ctrl_din;
  logic       ctrl_rd_ack;
  logic       ctrl_wr_ack;
  logic       ctrl_init_done;
  data_t      ctrl_dout;
  int         rd_burst_count;

  word_addr_t shadow_addr [$];  // every word written so far, in order
  data_t      shadow_data [$];
  int         reads_issued  = 0;
  int         reads_checked = 0;
  int         writes_issued = 0;
  int         writes_acked  = 0;
  logic       read_ack_d    = 1'b0;

  sdram_front_end i_sdram_front_end (.*);

  sdram_ctrl_model i_sdram_ctrl_model (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic data_t fill_pattern(input word_addr_t a);
    word_addr_t mix;
    mix = a * 22'h2c9b + (a >> 9) + 22'h3a5c;
    return mix[15:0];
  endfunction

  // latest written value wins, otherwise the power-up pattern
  function automatic data_t ref_word(input word_addr_t a);
    for (int i = shadow_addr.size() - 1; i >= 0; i--) begin
      if (shadow_addr[i] == a) begin
        return shadow_data[i];
      end
    end
    return fill_pattern(a);
  endfunction

  function automatic word_addr_t random_addr();
    logic [31:0] r;
    r = $urandom;
    return r[21:0];
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic expect_low(input string name, input logic value);
    assert (value === 1'b0) else
      stop_with_failure($sformatf("MISMATCH %s: got 0x%h, expected 0x0", name, value));
  endtask

  task automatic wait_busy(input logic level, input string what);
    int cycles;
    cycles = 0;
    while (busy !== level) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_failure(what);
      end
    end
  endtask

  task automatic read_word(input word_addr_t a);
    int cycles;
    cycles       = 0;
    address      = a;
    read_req     = 1'b1;
    reads_issued = reads_issued + 1;
    while (!read_ack) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_failure("timeout while waiting for read_ack");
      end
    end
    read_req = 1'b0;
    cycles   = 0;
    while (read_ack) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_failure("read_ack stayed high after read_req was released");
      end
    end
    assert (data_out == '0) else
      stop_with_failure($sformatf("MISMATCH data_out: got 0x%h, expected 0x0000", data_out));
  endtask

  task automatic write_single(input word_addr_t a, input data_t d);
    int cycles;
    cycles        = 0;
    address       = a;
    data_in       = d;
    write_req     = 1'b1;
    writes_issued = writes_issued + 1;
    while (!write_ack) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_with_failure("timeout while waiting for write_ack");
      end
    end
    write_req = 1'b0;
    shadow_addr.push_back(a);
    shadow_data.push_back(d);
    @(negedge clk);
    expect_low("write_ack", write_ack);  // one-cycle pulse
  endtask

  task automatic stream_words(input word_addr_t base, input int count);
    logic [31:0] r;
    address             = base;
    write_latch_address = 1'b1;
    @(negedge clk);
    write_latch_address = 1'b0;
    for (int i = 0; i < count; i++) begin
      r        = $urandom;
      data_in  = r[15:0];
      write_en = 1'b1;
      shadow_addr.push_back(base + i[21:0]);
      shadow_data.push_back(r[15:0]);
      @(negedge clk);
      write_en = 1'b0;
      if (i % PAGE_WORDS == PAGE_WORDS - 1) begin
        wait_busy(1'b1, "timeout while waiting for the page flush to start");
        wait_busy(1'b0, "timeout while waiting for the page flush to finish");
      end else if (r[31:30] == 2'b00) begin
        @(negedge clk);  // idle gap inside the stream
      end
    end
  endtask

  // checks every read answer as read_ack rises
  always @(posedge clk) begin
    if (sys_rst_n && read_ack && !read_ack_d) begin
      assert (data_out == ref_word(address)) else
        stop_with_failure($sformatf("MISMATCH data_out: got 0x%h, expected 0x%h at 0x%h",
                                    data_out, ref_word(address), address));
      reads_checked++;
    end
    read_ack_d = read_ack;
  end

  always @(posedge clk) begin
    if (sys_rst_n) begin
      assert (ctrl_init_done || !(ctrl_rd_req || ctrl_wr_req)) else
        stop_with_failure("controller request raised before init done");
      if (write_ack) begin
        writes_acked++;
      end
    end
  end

  initial begin
    word_addr_t  a;
    word_addr_t  base;
    line_tag_t   prev_line;
    logic [31:0] r;
    int          bursts_before;
    void'($urandom(32'h3db0));
    sys_rst_n           = 1'b0;
    address             = '0;
    data_in             = '0;
    read_req            = 1'b0;
    write_req           = 1'b0;
    write_latch_address = 1'b0;
    write_en            = 1'b0;
    prev_line           = '1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    sys_rst_n = 1'b1;
    @(negedge clk);
    expect_low("busy", busy);
    expect_low("read_ack", read_ack);
    expect_low("write_ack", write_ack);
    expect_low("ctrl_init_done", ctrl_init_done);  // first read waits for init

    for (int i = 0; i < 8; i++) begin
      do begin
        a = random_addr();
      end while (a[21:2] == prev_line);
      bursts_before = rd_burst_count;
      read_word(a);
      assert (rd_burst_count == bursts_before + 1) else
        stop_with_failure("read miss did not fetch exactly one line");
      read_word({a[21:2], a[1:0] + 2'd1});
      assert (rd_burst_count == bursts_before + 1) else
        stop_with_failure("read inside the cached line started a new burst");
      prev_line = a[21:2];
    end

    for (int i = 0; i < 4; i++) begin
      a = random_addr();
      read_word(a);
      r = $urandom;
      write_single(a, r[15:0]);
      bursts_before = rd_burst_count;
      read_word(a);
      assert (rd_burst_count == bursts_before + 1) else
        stop_with_failure("read after a write was served from a stale line");
      read_word({a[21:2], a[1:0] ^ 2'b10});
    end

    r    = $urandom;
    base = {r[17:0] % 18'h3fff0 + 18'd1, 4'h0};  // aligned page, room on both sides
    stream_words(base, 48);
    for (int i = 0; i < 48; i++) begin
      read_word(base + i[21:0]);
    end
    read_word(base - 22'd1);
    read_word(base + 22'd48);
    read_word(base + 22'd49);

    @(negedge clk);
    if (reads_checked == reads_issued && writes_acked == writes_issued) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      stop_with_failure($sformatf("%0d of %0d reads checked, %0d of %0d writes acknowledged",
                                  reads_checked, reads_issued, writes_acked, writes_issued));
    end
  end

endmodule

/* compile.f */
verilog/sdram_port_pkg.sv
verilog/burst_beat_counter.sv
verilog/read_line_cache.sv
verilog/write_stream_buffer.sv
verilog/sdram_arbiter_fsm.sv
verilog/sdram_front_end.sv
verification/sdram_ctrl_model.sv
verification/tb_sdram_front_end.sv

/* Bender.yml */
package:
  name: sdram_front_end

sources:
  - verilog/sdram_port_pkg.sv
  - verilog/burst_beat_counter.sv
  - verilog/read_line_cache.sv
  - verilog/write_stream_buffer.sv
  - verilog/sdram_arbiter_fsm.sv
  - verilog/sdram_front_end.sv
  - target: simulation
    files:
      - verification/sdram_ctrl_model.sv
      - verification/tb_sdram_front_end.sv
